//--- mem_subsystem.f
source/axi_pkg.sv
source/mem_map_pkg.sv
source/sram_bank.sv
source/slave_regs.sv
source/axi_slave_fsm.sv
source/mem_subsystem_top.sv
sim/clock_gen.sv
sim/mem_subsystem_chk.sv
sim/tb_mem_subsystem.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_mem_subsystem
FILELIST  := mem_subsystem.f
VFLAGS    := --binary --timing --assert -j 0
RUN_FLAGS := +verilator+error+limit+100
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := CHECKS FAILED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, a crashed run counts as failed as well
run: $(SIM_BIN)
	@$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_mem_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mem_subsystem
  import axi_pkg::*, mem_map_pkg::*;
();

  // about 115 transactions, none over 20 cycles even with stalls
  localparam int TXN_BOUND      = 200;
  localparam int TXN_CYCLES     = 20;
  localparam int TIMEOUT_CYCLES = TXN_BOUND * TXN_CYCLES;
  localparam int TEST_WORDS     = 16;
  localparam int RANDOM_PAIRS   = 24;
  localparam int STALL_PAIRS    = 16;

  logic                      clock;
  logic                      reset_n;
  logic                      axi_ar_valid_i;
  logic [AXI_ADDR_WIDTH-1:0] axi_ar_addr_i;
  logic [AXI_ID_WIDTH-1:0]   axi_ar_id_i;
  logic                      axi_r_ready_i;
  logic                      axi_ar_ready_o;
  logic                      axi_r_valid_o;
  logic [AXI_DATA_WIDTH-1:0] axi_r_data_o;
  logic [1:0]                axi_r_resp_o;
  logic                      axi_r_last_o;
  logic [AXI_ID_WIDTH-1:0]   axi_r_id_o;
  logic                      axi_aw_valid_i;
  logic [AXI_ADDR_WIDTH-1:0] axi_aw_addr_i;
  logic                      axi_w_valid_i;
  logic [AXI_DATA_WIDTH-1:0] axi_w_data_i;
  logic [AXI_STRB_WIDTH-1:0] axi_w_strb_i;
  logic                      axi_b_ready_i;
  logic                      axi_aw_ready_o;
  logic                      axi_w_ready_o;
  logic                      axi_b_valid_o;
  logic [1:0]                axi_b_resp_o;

  // reference model and bookkeeping
  logic [AXI_DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
  logic [AXI_DATA_WIDTH-1:0] ref_scratch;
  int wr_responses;
  int rd_responses;
  int checks;
  int errors;
  int cycles;
  int stall_max;
  int seed = 32'hfe1f_3d2b;

  clock_gen i_clock_gen (
    .clock_o   (clock),
    .reset_n_o (reset_n)
  );

  mem_subsystem_top i_mem_subsystem_top (.*);

  // memory view of an address, any region
  function automatic logic [AXI_ADDR_WIDTH-1:0] mem_address(
    input logic [3:0]                 region,
    input logic [MEM_INDEX_WIDTH-1:0] idx
  );
    axi_addr_u a;
    a            = '0;
    a.mem.region = region;
    a.mem.index  = idx;
    return a;
  endfunction

  // register view
  function automatic logic [AXI_ADDR_WIDTH-1:0] reg_address(input logic [1:0] idx);
    axi_addr_u a;
    a             = '0;
    a.regs.region = REGION_REGS;
    a.regs.index  = idx;
    return a;
  endfunction

  // strobed bytes replace, the rest keep the old value
  function automatic logic [63:0] merge_bytes(
    input logic [63:0] old_word,
    input logic [63:0] new_word,
    input logic [7:0]  strb
  );
    logic [63:0] merged;
    merged = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic logic [63:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // test words spread over the index range
  function automatic logic [MEM_INDEX_WIDTH-1:0] pick_word();
    int k;
    k = int'($unsigned($random(seed)) % TEST_WORDS);
    return MEM_INDEX_WIDTH'(k * 17);
  endfunction

  function automatic int stall_count();
    return int'($unsigned($random(seed)) % (stall_max + 1));
  endfunction

  task automatic check_value(
    input string       name,
    input logic [63:0] expected,
    input logic [63:0] actual
  );
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // called on a falling edge; ready and valid outputs depend on state only
  task automatic write_check(
    input string                     name,
    input logic [AXI_ADDR_WIDTH-1:0] addr,
    input logic [AXI_DATA_WIDTH-1:0] data,
    input logic [AXI_STRB_WIDTH-1:0] strb,
    input logic [1:0]                exp_resp
  );
    logic [1:0] resp;
    axi_aw_valid_i = 1'b1;
    axi_aw_addr_i  = addr;
    while (!axi_aw_ready_o) @(negedge clock);
    @(negedge clock);
    axi_aw_valid_i = 1'b0;
    // data beat
    axi_w_valid_i = 1'b1;
    axi_w_data_i  = data;
    axi_w_strb_i  = strb;
    while (!axi_w_ready_o) @(negedge clock);
    @(negedge clock);
    axi_w_valid_i = 1'b0;
    // response, held off for a random stretch
    while (!axi_b_valid_o) @(negedge clock);
    repeat (stall_count()) @(negedge clock);
    axi_b_ready_i = 1'b1;
    resp          = axi_b_resp_o;
    @(negedge clock);
    axi_b_ready_i = 1'b0;
    wr_responses++;
    check_value($sformatf("%s resp", name), 64'(exp_resp), 64'(resp));
  endtask

  task automatic read_check(
    input string                     name,
    input logic [AXI_ADDR_WIDTH-1:0] addr,
    input logic [AXI_DATA_WIDTH-1:0] exp_data,
    input logic [1:0]                exp_resp
  );
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [AXI_ID_WIDTH-1:0]   rid;
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [1:0]                resp;
    id             = AXI_ID_WIDTH'($random(seed));
    axi_ar_valid_i = 1'b1;
    axi_ar_addr_i  = addr;
    axi_ar_id_i    = id;
    while (!axi_ar_ready_o) @(negedge clock);
    @(negedge clock);
    axi_ar_valid_i = 1'b0;
    while (!axi_r_valid_o) @(negedge clock);
    repeat (stall_count()) @(negedge clock);
    axi_r_ready_i = 1'b1;
    data          = axi_r_data_o;
    resp          = axi_r_resp_o;
    rid           = axi_r_id_o;
    @(negedge clock);
    axi_r_ready_i = 1'b0;
    rd_responses++;
    check_value($sformatf("%s data", name), exp_data, data);
    check_value($sformatf("%s resp", name), 64'(exp_resp), 64'(resp));
    check_value($sformatf("%s id", name), 64'(id), 64'(rid));
  endtask

  // one random write then a read of the same word
  task automatic write_then_read(input string name);
    logic [MEM_INDEX_WIDTH-1:0] idx;
    logic [AXI_DATA_WIDTH-1:0]  wdata;
    logic [AXI_STRB_WIDTH-1:0]  strb;
    idx   = pick_word();
    wdata = random_word();
    strb  = AXI_STRB_WIDTH'($random(seed));
    write_check(name, mem_address(REGION_MEM, idx), wdata, strb, RESP_OKAY);
    ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, strb);
    read_check(name, mem_address(REGION_MEM, idx), ref_mem[idx], RESP_OKAY);
  endtask

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout after %0d cycles, a handshake never completed", cycles);
    $display("checks %0d, errors %0d", checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic [MEM_INDEX_WIDTH-1:0] idx;
    logic [AXI_ADDR_WIDTH-1:0]  addr;
    logic [AXI_DATA_WIDTH-1:0]  wdata;
    logic [AXI_STRB_WIDTH-1:0]  strb;
    int unsigned                assert_fails;
    axi_ar_valid_i = 1'b0;
    axi_ar_addr_i  = '0;
    axi_ar_id_i    = '0;
    axi_r_ready_i  = 1'b0;
    axi_aw_valid_i = 1'b0;
    axi_aw_addr_i  = '0;
    axi_w_valid_i  = 1'b0;
    axi_w_data_i   = '0;
    axi_w_strb_i   = '0;
    axi_b_ready_i  = 1'b0;
    wr_responses   = 0;
    rd_responses   = 0;
    checks         = 0;
    errors         = 0;
    stall_max      = 3;
    @(posedge reset_n);
    @(negedge clock);

    // idle state after reset
    check_value("reset ar_ready", 64'd1, 64'(axi_ar_ready_o));
    check_value("reset aw_ready", 64'd1, 64'(axi_aw_ready_o));
    check_value("reset r_valid", 64'd0, 64'(axi_r_valid_o));
    check_value("reset b_valid", 64'd0, 64'(axi_b_valid_o));
    read_check("protect after reset", reg_address(REG_PROTECT), 64'd0, RESP_OKAY);

    // full-word fill, pattern from the whole address
    for (int k = 0; k < TEST_WORDS; k++) begin
      idx   = MEM_INDEX_WIDTH'(k * 17);
      addr  = mem_address(REGION_MEM, idx);
      wdata = {~addr, addr};
      write_check("fill", addr, wdata, 8'hff, RESP_OKAY);
      ref_mem[idx] = wdata;
    end
    repeat (RANDOM_PAIRS) write_then_read("strobed");

    // write protect blocks memory writes only
    write_check("protect on", reg_address(REG_PROTECT), 64'd1, 8'h01, RESP_OKAY);
    read_check("protect readback", reg_address(REG_PROTECT), 64'd1, RESP_OKAY);
    idx = pick_word();
    write_check("protected write", mem_address(REGION_MEM, idx), random_word(), 8'hff,
                RESP_SLVERR);
    read_check("protected read", mem_address(REGION_MEM, idx), ref_mem[idx], RESP_OKAY);
    write_check("protect off", reg_address(REG_PROTECT), 64'd0, 8'h01, RESP_OKAY);
    wdata = random_word();
    write_check("unprotected write", mem_address(REGION_MEM, idx), wdata, 8'hff, RESP_OKAY);
    ref_mem[idx] = wdata;
    read_check("unprotected read", mem_address(REGION_MEM, idx), ref_mem[idx], RESP_OKAY);

    // region 3 is unmapped, must not alias word 17
    write_check("unmapped write", mem_address(4'h3, 8'd17), random_word(), 8'hff,
                RESP_DECERR);
    read_check("unmapped read", mem_address(4'h3, 8'd17), 64'd0, RESP_DECERR);
    read_check("no alias", mem_address(REGION_MEM, 8'd17), ref_mem[17], RESP_OKAY);

    // counters exclude the read in flight
    read_check("write count", reg_address(REG_WRCOUNT), 64'(wr_responses), RESP_OKAY);
    read_check("read count", reg_address(REG_RDCOUNT), 64'(rd_responses), RESP_OKAY);
    write_check("count write", reg_address(REG_WRCOUNT), 64'hffff, 8'hff, RESP_OKAY);
    read_check("count kept", reg_address(REG_WRCOUNT), 64'(wr_responses), RESP_OKAY);
    ref_scratch = random_word();
    write_check("scratch write", reg_address(REG_SCRATCH), ref_scratch, 8'hff, RESP_OKAY);
    wdata = random_word();
    strb  = AXI_STRB_WIDTH'($random(seed));
    write_check("scratch strobed", reg_address(REG_SCRATCH), wdata, strb, RESP_OKAY);
    ref_scratch = merge_bytes(ref_scratch, wdata, strb);
    read_check("scratch readback", reg_address(REG_SCRATCH), ref_scratch, RESP_OKAY);

    // long back-pressure on r and b
    stall_max = 7;
    repeat (STALL_PAIRS) write_then_read("stalled");
    read_check("write count end", reg_address(REG_WRCOUNT), 64'(wr_responses), RESP_OKAY);
    read_check("read count end", reg_address(REG_RDCOUNT), 64'(rd_responses), RESP_OKAY);

    assert_fails = i_mem_subsystem_top.i_mem_subsystem_chk.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/mem_subsystem_chk.sv
`default_nettype none
`timescale 1ns/1ps

module mem_subsystem_chk
  import axi_pkg::*;
(
  input wire                      clock,
  input wire                      reset_n,
  input wire                      ar_ready_i,
  input wire                      aw_ready_i,
  input wire                      w_ready_i,
  input wire                      r_valid_i,
  input wire                      r_ready_i,
  input wire [AXI_DATA_WIDTH-1:0] r_data_i,
  input wire [1:0]                r_resp_i,
  input wire [AXI_ID_WIDTH-1:0]   r_id_i,
  input wire                      r_last_i,
  input wire                      b_valid_i,
  input wire                      b_ready_i,
  input wire [1:0]                b_resp_i
);

  // failure tallies, one per property
  int unsigned r_hold_fails = 0;
  int unsigned b_hold_fails = 0;
  int unsigned last_fails   = 0;
  int unsigned busy_fails   = 0;
  int unsigned reset_fails  = 0;
  int unsigned fail_count;

  assign fail_count = r_hold_fails + b_hold_fails + last_fails + busy_fails + reset_fails;

  // r response frozen while the master stalls
  r_hold: assert property (
    @(posedge clock) disable iff (!reset_n)
    r_valid_i && !r_ready_i |=>
      r_valid_i && $stable(r_data_i) && $stable(r_resp_i) && $stable(r_id_i)
  ) else begin
    $error("r channel changed while r_ready was low");
    r_hold_fails++;
  end

  // b response frozen the same way
  b_hold: assert property (
    @(posedge clock) disable iff (!reset_n)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i)
  ) else begin
    $error("b channel changed while b_ready was low");
    b_hold_fails++;
  end

  // single beat, so last goes with every valid
  r_last_with_valid: assert property (
    @(posedge clock) disable iff (!reset_n)
    r_valid_i |-> r_last_i
  ) else begin
    $error("r_last low during a read response");
    last_fails++;
  end

  // no new address taken while its response is pending
  addr_blocked: assert property (
    @(posedge clock) disable iff (!reset_n)
    !((r_valid_i && ar_ready_i) || (b_valid_i && aw_ready_i))
  ) else begin
    $error("address ready high with a response pending");
    busy_fails++;
  end

  // idle outputs on the edge after reset
  reset_idle: assert property (
    @(posedge clock)
    !reset_n |=> !r_valid_i && !b_valid_i && !w_ready_i && ar_ready_i && aw_ready_i
  ) else begin
    $error("outputs not idle after reset");
    reset_fails++;
  end

endmodule

bind mem_subsystem_top mem_subsystem_chk i_mem_subsystem_chk (
  .clock      (clock),
  .reset_n    (reset_n),
  .ar_ready_i (axi_ar_ready_o),
  .aw_ready_i (axi_aw_ready_o),
  .w_ready_i  (axi_w_ready_o),
  .r_valid_i  (axi_r_valid_o),
  .r_ready_i  (axi_r_ready_i),
  .r_data_i   (axi_r_data_o),
  .r_resp_i   (axi_r_resp_o),
  .r_id_i     (axi_r_id_o),
  .r_last_i   (axi_r_last_o),
  .b_valid_i  (axi_b_valid_o),
  .b_ready_i  (axi_b_ready_i),
  .b_resp_i   (axi_b_resp_o)
);

`default_nettype wire

//--- sim/clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module clock_gen (
  output logic clock_o,
  output logic reset_n_o
);

  // 4 ns period
  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 8;

  initial begin
    clock_o = 1'b0;
    forever #(HALF_PERIOD) clock_o = ~clock_o;
  end

  // reset low for 8 rising edges, released on a falling edge
  initial begin
    reset_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_o);
    @(negedge clock_o);
    reset_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- source/mem_subsystem_top.sv
`default_nettype none
`timescale 1ns/1ps

module mem_subsystem_top
  import axi_pkg::*, mem_map_pkg::*;
(
  input  wire                        clock,
  input  wire                        reset_n,
  // read channels
  input  wire                        axi_ar_valid_i,
  input  wire [AXI_ADDR_WIDTH-1:0]   axi_ar_addr_i,
  input  wire [AXI_ID_WIDTH-1:0]     axi_ar_id_i,
  input  wire                        axi_r_ready_i,
  output logic                       axi_ar_ready_o,
  output logic                       axi_r_valid_o,
  output logic [AXI_DATA_WIDTH-1:0]  axi_r_data_o,
  output logic [1:0]                 axi_r_resp_o,
  output logic                       axi_r_last_o,
  output logic [AXI_ID_WIDTH-1:0]    axi_r_id_o,
  // write channels
  input  wire                        axi_aw_valid_i,
  input  wire [AXI_ADDR_WIDTH-1:0]   axi_aw_addr_i,
  input  wire                        axi_w_valid_i,
  input  wire [AXI_DATA_WIDTH-1:0]   axi_w_data_i,
  input  wire [AXI_STRB_WIDTH-1:0]   axi_w_strb_i,
  input  wire                        axi_b_ready_i,
  output logic                       axi_aw_ready_o,
  output logic                       axi_w_ready_o,
  output logic                       axi_b_valid_o,
  output logic [1:0]                 axi_b_resp_o
);

  // FSM to sram
  logic                       mem_re;
  logic [MEM_INDEX_WIDTH-1:0] mem_raddr;
  logic                       mem_we;
  logic [MEM_INDEX_WIDTH-1:0] mem_waddr;
  logic [AXI_DATA_WIDTH-1:0]  mem_wdata;
  logic [AXI_STRB_WIDTH-1:0]  mem_strb;
  logic [AXI_DATA_WIDTH-1:0]  mem_rdata;

  // FSM to register block
  logic                       reg_we;
  logic [1:0]                 reg_index;
  logic [AXI_DATA_WIDTH-1:0]  reg_wdata;
  logic [AXI_STRB_WIDTH-1:0]  reg_strb;
  logic                       wr_done;
  logic                       rd_done;
  logic [AXI_DATA_WIDTH-1:0]  reg_rdata;
  logic                       write_protect;

  axi_slave_fsm i_axi_slave_fsm (
    .clock           (clock),
    .reset_n         (reset_n),
    .axi_ar_valid_i  (axi_ar_valid_i),
    .axi_ar_addr_i   (axi_ar_addr_i),
    .axi_ar_id_i     (axi_ar_id_i),
    .axi_r_ready_i   (axi_r_ready_i),
    .axi_ar_ready_o  (axi_ar_ready_o),
    .axi_r_valid_o   (axi_r_valid_o),
    .axi_r_data_o    (axi_r_data_o),
    .axi_r_resp_o    (axi_r_resp_o),
    .axi_r_last_o    (axi_r_last_o),
    .axi_r_id_o      (axi_r_id_o),
    .axi_aw_valid_i  (axi_aw_valid_i),
    .axi_aw_addr_i   (axi_aw_addr_i),
    .axi_w_valid_i   (axi_w_valid_i),
    .axi_w_data_i    (axi_w_data_i),
    .axi_w_strb_i    (axi_w_strb_i),
    .axi_b_ready_i   (axi_b_ready_i),
    .axi_aw_ready_o  (axi_aw_ready_o),
    .axi_w_ready_o   (axi_w_ready_o),
    .axi_b_valid_o   (axi_b_valid_o),
    .axi_b_resp_o    (axi_b_resp_o),
    .mem_re_o        (mem_re),
    .mem_raddr_o     (mem_raddr),
    .mem_we_o        (mem_we),
    .mem_waddr_o     (mem_waddr),
    .mem_wdata_o     (mem_wdata),
    .mem_strb_o      (mem_strb),
    .mem_rdata_i     (mem_rdata),
    .reg_we_o        (reg_we),
    .reg_index_o     (reg_index),
    .reg_wdata_o     (reg_wdata),
    .reg_strb_o      (reg_strb),
    .wr_done_o       (wr_done),
    .rd_done_o       (rd_done),
    .reg_rdata_i     (reg_rdata),
    .write_protect_i (write_protect)
  );

  // main memory at region 8
  sram_bank i_sram_bank (
    .clock   (clock),
    .re_i    (mem_re),
    .raddr_i (mem_raddr),
    .rdata_o (mem_rdata),
    .we_i    (mem_we),
    .waddr_i (mem_waddr),
    .wdata_i (mem_wdata),
    .strb_i  (mem_strb)
  );

  // control registers at region 1
  slave_regs i_slave_regs (
    .clock           (clock),
    .reset_n         (reset_n),
    .we_i            (reg_we),
    .index_i         (reg_index),
    .wdata_i         (reg_wdata),
    .strb_i          (reg_strb),
    .wr_done_i       (wr_done),
    .rd_done_i       (rd_done),
    .rdata_o         (reg_rdata),
    .write_protect_o (write_protect)
  );

endmodule

`default_nettype wire

//--- source/axi_slave_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module axi_slave_fsm
  import axi_pkg::*, mem_map_pkg::*;
(
  input  wire                        clock,
  input  wire                        reset_n,
  // read address and data channels
  input  wire                        axi_ar_valid_i,
  input  wire [AXI_ADDR_WIDTH-1:0]   axi_ar_addr_i,
  input  wire [AXI_ID_WIDTH-1:0]     axi_ar_id_i,
  input  wire                        axi_r_ready_i,
  output logic                       axi_ar_ready_o,
  output logic                       axi_r_valid_o,
  output logic [AXI_DATA_WIDTH-1:0]  axi_r_data_o,
  output logic [1:0]                 axi_r_resp_o,
  output logic                       axi_r_last_o,
  output logic [AXI_ID_WIDTH-1:0]    axi_r_id_o,
  // write address, data and response channels
  input  wire                        axi_aw_valid_i,
  input  wire [AXI_ADDR_WIDTH-1:0]   axi_aw_addr_i,
  input  wire                        axi_w_valid_i,
  input  wire [AXI_DATA_WIDTH-1:0]   axi_w_data_i,
  input  wire [AXI_STRB_WIDTH-1:0]   axi_w_strb_i,
  input  wire                        axi_b_ready_i,
  output logic                       axi_aw_ready_o,
  output logic                       axi_w_ready_o,
  output logic                       axi_b_valid_o,
  output logic [1:0]                 axi_b_resp_o,
  // sram bank side
  output logic                       mem_re_o,
  output logic [MEM_INDEX_WIDTH-1:0] mem_raddr_o,
  output logic                       mem_we_o,
  output logic [MEM_INDEX_WIDTH-1:0] mem_waddr_o,
  output logic [AXI_DATA_WIDTH-1:0]  mem_wdata_o,
  output logic [AXI_STRB_WIDTH-1:0]  mem_strb_o,
  input  wire [AXI_DATA_WIDTH-1:0]   mem_rdata_i,
  // register block side
  output logic                       reg_we_o,
  output logic [1:0]                 reg_index_o,
  output logic [AXI_DATA_WIDTH-1:0]  reg_wdata_o,
  output logic [AXI_STRB_WIDTH-1:0]  reg_strb_o,
  output logic                       wr_done_o,
  output logic                       rd_done_o,
  input  wire [AXI_DATA_WIDTH-1:0]   reg_rdata_i,
  input  wire                        write_protect_i
);

  // handshakes
  logic ar_hs, r_hs, aw_hs, w_hs, b_hs;

  // incoming read address and latched write address, both views
  axi_addr_u ar_addr;
  axi_addr_u aw_addr_q;
  logic      ar_mem_hit, ar_reg_hit;
  logic      wr_mem_hit, wr_reg_hit;

  // read side: busy means response pending
  logic                      r_busy_q;
  logic                      rd_mem_q, rd_reg_q;
  logic [AXI_DATA_WIDTH-1:0] rd_reg_data_q;
  logic [AXI_ID_WIDTH-1:0]   rd_id_q;
  logic [1:0]                rd_resp_q;

  // write side: data phase, then response phase
  logic       w_data_q, w_resp_q;
  logic [1:0] b_resp_q;
  logic       reg_wr_now;

  assign ar_hs = axi_ar_valid_i & axi_ar_ready_o;
  assign r_hs  = axi_r_valid_o & axi_r_ready_i;
  assign aw_hs = axi_aw_valid_i & axi_aw_ready_o;
  assign w_hs  = axi_w_valid_i & axi_w_ready_o;
  assign b_hs  = axi_b_valid_o & axi_b_ready_i;

  // region decode
  assign ar_addr    = axi_ar_addr_i;
  assign ar_mem_hit = (ar_addr.mem.region == REGION_MEM);
  assign ar_reg_hit = (ar_addr.regs.region == REGION_REGS);
  assign wr_mem_hit = (aw_addr_q.mem.region == REGION_MEM);
  assign wr_reg_hit = (aw_addr_q.regs.region == REGION_REGS);

  // register write this cycle, owns the shared register index
  assign reg_wr_now = w_hs & wr_reg_hit;

  // read FSM, idle until ar, respond until r
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      r_busy_q <= 1'b0;
    end else if (ar_hs) begin
      r_busy_q <= 1'b1;
    end else if (r_hs) begin
      r_busy_q <= 1'b0;
    end
  end

  // read payload captured at the address handshake
  always_ff @(posedge clock) begin
    if (ar_hs) begin
      rd_id_q       <= axi_ar_id_i;
      rd_mem_q      <= ar_mem_hit;
      rd_reg_q      <= ar_reg_hit;
      rd_reg_data_q <= reg_rdata_i;
      rd_resp_q     <= (ar_mem_hit | ar_reg_hit) ? RESP_OKAY : RESP_DECERR;
    end
  end

  // ar stalls one cycle only if a register write holds the index
  assign axi_ar_ready_o = ~r_busy_q & ~reg_wr_now;
  assign axi_r_valid_o  = r_busy_q;
  // single beat, every beat is the last
  assign axi_r_last_o   = r_busy_q;
  assign axi_r_id_o     = rd_id_q;
  assign axi_r_resp_o   = rd_resp_q;
  // sram output only moves on a new ar, so it holds under stall
  assign axi_r_data_o   = rd_mem_q ? mem_rdata_i :
                          rd_reg_q ? rd_reg_data_q : '0;

  // memory read issued with the address handshake
  assign mem_re_o    = ar_hs & ar_mem_hit;
  assign mem_raddr_o = ar_addr.mem.index;

  // write FSM, idle -> data -> respond
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      w_data_q <= 1'b0;
      w_resp_q <= 1'b0;
    end else begin
      if (aw_hs) begin
        w_data_q <= 1'b1;
      end else if (w_hs) begin
        w_data_q <= 1'b0;
      end
      if (w_hs) begin
        w_resp_q <= 1'b1;
      end else if (b_hs) begin
        w_resp_q <= 1'b0;
      end
    end
  end

  // latched write address
  always_ff @(posedge clock) begin
    if (aw_hs) begin
      aw_addr_q <= axi_aw_addr_i;
    end
  end

  // write response decided at the data handshake
  always_ff @(posedge clock) begin
    if (w_hs) begin
      if (wr_mem_hit) begin
        b_resp_q <= write_protect_i ? RESP_SLVERR : RESP_OKAY;
      end else if (wr_reg_hit) begin
        b_resp_q <= RESP_OKAY;
      end else begin
        b_resp_q <= RESP_DECERR;
      end
    end
  end

  assign axi_aw_ready_o = ~w_data_q & ~w_resp_q;
  assign axi_w_ready_o  = w_data_q;
  assign axi_b_valid_o  = w_resp_q;
  assign axi_b_resp_o   = b_resp_q;

  // memory write, dropped while protected
  assign mem_we_o    = w_hs & wr_mem_hit & ~write_protect_i;
  assign mem_waddr_o = aw_addr_q.mem.index;
  assign mem_wdata_o = axi_w_data_i;
  assign mem_strb_o  = axi_w_strb_i;

  // register write, counters ignore it inside the block
  assign reg_we_o    = reg_wr_now;
  assign reg_index_o = reg_wr_now ? aw_addr_q.regs.index : ar_addr.regs.index;
  assign reg_wdata_o = axi_w_data_i;
  assign reg_strb_o  = axi_w_strb_i;

  // completed responses, errors included
  assign wr_done_o = b_hs;
  assign rd_done_o = r_hs;

endmodule

`default_nettype wire

//--- source/slave_regs.sv
`default_nettype none
`timescale 1ns/1ps

module slave_regs
  import axi_pkg::*, mem_map_pkg::*;
(
  input  wire                        clock,
  input  wire                        reset_n,
  // write side, one register per cycle
  input  wire                        we_i,
  input  wire [1:0]                  index_i,
  input  wire [AXI_DATA_WIDTH-1:0]   wdata_i,
  input  wire [AXI_STRB_WIDTH-1:0]   strb_i,
  // completed response pulses
  input  wire                        wr_done_i,
  input  wire                        rd_done_i,
  output logic [AXI_DATA_WIDTH-1:0]  rdata_o,
  output logic                       write_protect_o
);

  logic                      protect_q;
  logic [31:0]               wr_count_q;
  logic [31:0]               rd_count_q;
  logic [AXI_DATA_WIDTH-1:0] scratch_q;

  // protect bit lives in byte 0
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      protect_q <= 1'b0;
    end else if (we_i && index_i == REG_PROTECT && strb_i[0]) begin
      protect_q <= wdata_i[0];
    end
  end

  // scratch word, plain storage
  always_ff @(posedge clock) begin
    if (we_i && index_i == REG_SCRATCH) begin
      for (int b = 0; b < AXI_STRB_WIDTH; b++) begin
        if (strb_i[b]) begin
          scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // response counters, no write path
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      wr_count_q <= '0;
      rd_count_q <= '0;
    end else begin
      if (wr_done_i) begin
        wr_count_q <= wr_count_q + 32'd1;
      end
      if (rd_done_i) begin
        rd_count_q <= rd_count_q + 32'd1;
      end
    end
  end

  // read mux, sampled by the FSM at the ar handshake
  always_comb begin
    case (index_i)
      REG_PROTECT: rdata_o = {{(AXI_DATA_WIDTH-1){1'b0}}, protect_q};
      REG_WRCOUNT: rdata_o = {32'd0, wr_count_q};
      REG_RDCOUNT: rdata_o = {32'd0, rd_count_q};
      default:     rdata_o = scratch_q;
    endcase
  end

  assign write_protect_o = protect_q;

endmodule

`default_nettype wire

//--- source/sram_bank.sv
`default_nettype none
`timescale 1ns/1ps

module sram_bank
  import axi_pkg::*, mem_map_pkg::*;
(
  input  wire                        clock,
  // read port
  input  wire                        re_i,
  input  wire [MEM_INDEX_WIDTH-1:0]  raddr_i,
  output logic [AXI_DATA_WIDTH-1:0]  rdata_o,
  // write port
  input  wire                        we_i,
  input  wire [MEM_INDEX_WIDTH-1:0]  waddr_i,
  input  wire [AXI_DATA_WIDTH-1:0]   wdata_i,
  input  wire [AXI_STRB_WIDTH-1:0]   strb_i
);

  // word array, contents undefined until written
  logic [AXI_DATA_WIDTH-1:0] mem_q [MEM_WORDS];

  // byte-strobed write
  always_ff @(posedge clock) begin
    if (we_i) begin
      for (int b = 0; b < AXI_STRB_WIDTH; b++) begin
        if (strb_i[b]) begin
          mem_q[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // registered read
  // same-word write in the same cycle, old data comes out
  // output holds between reads
  always_ff @(posedge clock) begin
    if (re_i) begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

`default_nettype wire

//--- source/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  // top address nibble picks the target
  localparam logic [3:0] REGION_MEM  = 4'h8;
  localparam logic [3:0] REGION_REGS = 4'h1;

  // sram bank size in 64-bit words
  localparam int MEM_WORDS       = 256;
  localparam int MEM_INDEX_WIDTH = 8;

  // register block indices
  localparam logic [1:0] REG_PROTECT = 2'd0;
  // write response count, read only
  localparam logic [1:0] REG_WRCOUNT = 2'd1;
  // read response count, read only
  localparam logic [1:0] REG_RDCOUNT = 2'd2;
  localparam logic [1:0] REG_SCRATCH = 2'd3;

  // memory view of an address
  typedef struct packed {
    logic [3:0]                 region;
    logic [16:0]                unused;
    logic [MEM_INDEX_WIDTH-1:0] index;
    logic [2:0]                 offset;
  } mem_addr_t;

  // register view of the same address
  typedef struct packed {
    logic [3:0]  region;
    logic [22:0] unused;
    logic [1:0]  index;
    logic [2:0]  offset;
  } reg_addr_t;

  // one address word, two decodes
  typedef union packed {
    mem_addr_t mem;
    reg_addr_t regs;
  } axi_addr_u;

endpackage

`default_nettype wire

//--- source/axi_pkg.sv
`default_nettype none

package axi_pkg;

  // data bus, one 64-bit beat per transfer
  localparam int AXI_DATA_WIDTH = 64;

  // byte address, region in the top nibble
  localparam int AXI_ADDR_WIDTH = 32;

  // read id, echoed back on r
  localparam int AXI_ID_WIDTH = 4;

  // one strobe per data byte
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  // response codes as on the bus
  // exokay is never returned, no exclusive access here
  localparam logic [1:0] RESP_OKAY   = 2'b00;

  // slave error, memory write while protected
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // decode error, nothing mapped at this region
  localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage

`default_nettype wire
